//--- src/alu_pkg.sv
// shared ALU types; byte and pair widths are fixed by the instruction set, opcodes 22..31 undefined
package alu_pkg;

	// data widths of the practice CPU
	localparam int byte_w = 8;
	localparam int pair_w = 2 * byte_w;

	typedef logic [byte_w-1:0] byte_t;
	// high byte above low byte
	typedef logic [pair_w-1:0] pair_t;
	// shift count, low byte of b
	typedef logic [byte_w-1:0] shamt_t;

	// c after a subtract means no borrow
	typedef struct packed
	{
		logic c;
		logic z;
	} flags_t;

	// kept opcodes, rotates removed
	typedef enum logic [4:0]
	{
		op_add     = 5'd0,
		op_adc     = 5'd1,
		op_addpb   = 5'd2,
		op_addp    = 5'd3,
		op_addpsnx = 5'd4,
		op_sub     = 5'd5,
		op_sbc     = 5'd6,
		op_subpb   = 5'd7,
		op_subp    = 5'd8,
		op_and     = 5'd9,
		op_orr     = 5'd10,
		op_xor     = 5'd11,
		op_inv     = 5'd12,
		op_invp    = 5'd13,
		op_neg     = 5'd14,
		op_negp    = 5'd15,
		op_lsl     = 5'd16,
		op_lsr     = 5'd17,
		op_asr     = 5'd18,
		op_lslp    = 5'd19,
		op_lsrp    = 5'd20,
		op_asrp    = 5'd21
	} alu_op_t;

	// which width the zero flag looks at
	typedef enum logic
	{
		class_byte = 1'b0,
		class_pair = 1'b1
	} op_class_t;

	typedef struct packed
	{
		alu_op_t op;
		pair_t   a;
		pair_t   b;
		flags_t  flags;
	} alu_req_t;

	// stage 1 output
	typedef struct packed
	{
		alu_req_t  req;
		op_class_t op_class;
		logic      hold;
	} dec_t;

	// stage 2 output, flags_in kept for the hold case
	typedef struct packed
	{
		pair_t     result;
		logic      c;
		op_class_t op_class;
		logic      hold;
		flags_t    flags_in;
	} exe_t;

	typedef struct packed
	{
		pair_t  result;
		flags_t flags;
	} alu_res_t;

	// add/subtract family goes through the adder
	function automatic logic is_addsub(alu_op_t op);
		return op inside {op_add, op_adc, op_addpb, op_addp, op_addpsnx,
			op_sub, op_sbc, op_subpb, op_subp};
	endfunction

endpackage

//--- src/alu_decode.sv
// stage 1: accepts req on every in_valid edge with no ready; payload regs are not reset
module alu_decode
(
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  alu_pkg::alu_req_t req,
	output alu_pkg::dec_t     dec,
	output logic              dec_valid
);

	import alu_pkg::*;

	shamt_t    shamt;
	op_class_t op_class;
	logic      hold;

	// shift count lives in the low byte of b
	assign shamt = req.b[byte_w-1:0];

	// classify the opcode, flag the do-nothing cases
	always_comb
	begin
		op_class = class_byte;
		hold = 1'b0;
		case (req.op)
			op_add, op_adc, op_sub, op_sbc,
			op_and, op_orr, op_xor, op_inv, op_neg:
				op_class = class_byte;
			op_addpb, op_addp, op_addpsnx, op_subpb, op_subp,
			op_invp, op_negp:
				op_class = class_pair;
			// shift by zero leaves everything alone
			op_lsl, op_lsr, op_asr:
			begin
				op_class = class_byte;
				hold = (shamt == '0);
			end
			op_lslp, op_lsrp, op_asrp:
			begin
				op_class = class_pair;
				hold = (shamt == '0);
			end
			// undefined code passes a through
			default:
			begin
				op_class = class_pair;
				hold = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= in_valid;
	end

	// payload only loads on accepted requests
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			dec.req <= req;
			dec.op_class <= op_class;
			dec.hold <= hold;
		end
	end

endmodule

//--- src/addsub_unit.sv
// combinational add/subtract family; non-adder opcodes give a zero sum and zero carry
module addsub_unit
(
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::pair_t   a,
	input  alu_pkg::pair_t   b,
	input  logic             c_in,
	output alu_pkg::pair_t   sum,
	output logic             c_out
);

	import alu_pkg::*;

	pair_t           opa;
	pair_t           opb;
	logic            cin;
	logic            byte_op;
	logic [pair_w:0] sum_full;

	// operand prep per opcode
	always_comb
	begin
		opa = '0;
		opb = '0;
		cin = 1'b0;
		byte_op = 1'b0;
		case (op)
			op_add, op_adc:
			begin
				opa = {{byte_w{1'b0}}, a[byte_w-1:0]};
				opb = {{byte_w{1'b0}}, b[byte_w-1:0]};
				// adc folds in the carry flag
				cin = (op == op_adc) ? c_in : 1'b0;
				byte_op = 1'b1;
			end
			op_sub, op_sbc:
			begin
				opa = {{byte_w{1'b0}}, a[byte_w-1:0]};
				opb = {{byte_w{1'b0}}, ~b[byte_w-1:0]};
				// sbc uses carry as not-borrow
				cin = (op == op_sbc) ? c_in : 1'b1;
				byte_op = 1'b1;
			end
			op_addpb:
			begin
				opa = a;
				opb = {{byte_w{1'b0}}, b[byte_w-1:0]};
			end
			op_addp:
			begin
				opa = a;
				opb = b;
			end
			op_addpsnx:
			begin
				opa = a;
				// sign extended low byte of b
				opb = {{byte_w{b[byte_w-1]}}, b[byte_w-1:0]};
			end
			op_subpb:
			begin
				opa = a;
				opb = ~{{byte_w{1'b0}}, b[byte_w-1:0]};
				cin = 1'b1;
			end
			op_subp:
			begin
				opa = a;
				opb = ~b;
				cin = 1'b1;
			end
			default:
				opa = '0;
		endcase
	end

	// one bit wider than a pair
	assign sum_full = {1'b0, opa} + {1'b0, opb} + {{pair_w{1'b0}}, cin};

	// byte ops carry out of bit 8, high byte forced clear
	assign sum = byte_op ? {{byte_w{1'b0}}, sum_full[byte_w-1:0]} : sum_full[pair_w-1:0];
	assign c_out = byte_op ? sum_full[byte_w] : sum_full[pair_w];

endmodule

//--- src/shift_logic_unit.sv
// combinational logic, complement and shifts; shift count zero is handled as hold upstream
module shift_logic_unit
(
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::pair_t   a,
	input  alu_pkg::byte_t   b_lo,
	input  logic             c_in,
	output alu_pkg::pair_t   value,
	output logic             c_out
);

	import alu_pkg::*;

	byte_t           a_lo;
	shamt_t          shamt;
	logic [byte_w:0] sh_byte;
	logic [pair_w:0] sh_pair;

	assign a_lo = a[byte_w-1:0];
	assign shamt = b_lo;

	always_comb
	begin
		value = '0;
		c_out = 1'b0;
		sh_byte = '0;
		sh_pair = '0;
		case (op)
			// logic group, carry untouched
			op_and:
			begin
				value = {{byte_w{1'b0}}, a_lo & b_lo};
				c_out = c_in;
			end
			op_orr:
			begin
				value = {{byte_w{1'b0}}, a_lo | b_lo};
				c_out = c_in;
			end
			op_xor:
			begin
				value = {{byte_w{1'b0}}, a_lo ^ b_lo};
				c_out = c_in;
			end
			// complement and negate, carry untouched
			op_inv:
			begin
				value = {{byte_w{1'b0}}, ~a_lo};
				c_out = c_in;
			end
			op_neg:
			begin
				value = {{byte_w{1'b0}}, byte_t'(~a_lo + 1'b1)};
				c_out = c_in;
			end
			op_invp:
			begin
				value = ~a;
				c_out = c_in;
			end
			op_negp:
			begin
				value = pair_t'(~a + 1'b1);
				c_out = c_in;
			end
			// extra bit above the msb catches the last bit out
			op_lsl:
			begin
				sh_byte = {1'b0, a_lo} << shamt;
				value = {{byte_w{1'b0}}, sh_byte[byte_w-1:0]};
				c_out = sh_byte[byte_w];
			end
			op_lslp:
			begin
				sh_pair = {1'b0, a} << shamt;
				value = sh_pair[pair_w-1:0];
				c_out = sh_pair[pair_w];
			end
			// right shifts catch it below the lsb
			op_lsr:
			begin
				sh_byte = {a_lo, 1'b0} >> shamt;
				value = {{byte_w{1'b0}}, sh_byte[byte_w:1]};
				c_out = sh_byte[0];
			end
			op_lsrp:
			begin
				sh_pair = {a, 1'b0} >> shamt;
				value = sh_pair[pair_w:1];
				c_out = sh_pair[0];
			end
			// sign fills in, so c ends up as the sign for big counts
			op_asr:
			begin
				sh_byte = $signed({a_lo, 1'b0}) >>> shamt;
				value = {{byte_w{1'b0}}, sh_byte[byte_w:1]};
				c_out = sh_byte[0];
			end
			op_asrp:
			begin
				sh_pair = $signed({a, 1'b0}) >>> shamt;
				value = sh_pair[pair_w:1];
				c_out = sh_pair[0];
			end
			default:
				value = '0;
		endcase
	end

endmodule

//--- src/alu_execute.sv
// stage 2: both units are combinational here, so this stage sets the clock period
module alu_execute
(
	input  logic            clk,
	input  logic            reset,
	input  alu_pkg::dec_t   dec,
	input  logic            dec_valid,
	output alu_pkg::exe_t   exe,
	output logic            exe_valid
);

	import alu_pkg::*;

	pair_t as_sum;
	logic  as_c;
	pair_t sl_value;
	logic  sl_c;
	pair_t result;
	logic  c;

	addsub_unit u_addsub
	(
		.op    (dec.req.op),
		.a     (dec.req.a),
		.b     (dec.req.b),
		.c_in  (dec.req.flags.c),
		.sum   (as_sum),
		.c_out (as_c)
	);

	shift_logic_unit u_shift_logic
	(
		.op    (dec.req.op),
		.a     (dec.req.a),
		.b_lo  (dec.req.b[byte_w-1:0]),
		.c_in  (dec.req.flags.c),
		.value (sl_value),
		.c_out (sl_c)
	);

	// hold wins over both units
	always_comb
	begin
		if (dec.hold)
		begin
			result = dec.req.a;
			c = dec.req.flags.c;
		end
		else if (is_addsub(dec.req.op))
		begin
			result = as_sum;
			c = as_c;
		end
		else
		begin
			result = sl_value;
			c = sl_c;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			exe_valid <= 1'b0;
		else
			exe_valid <= dec_valid;
	end

	always_ff @(posedge clk)
	begin
		if (dec_valid)
		begin
			exe.result <= result;
			exe.c <= c;
			exe.op_class <= dec.op_class;
			exe.hold <= dec.hold;
			exe.flags_in <= dec.req.flags;
		end
	end

endmodule

//--- src/alu_flags.sv
// stage 3: res holds its last value between results; only out_valid is reset
module alu_flags
(
	input  logic              clk,
	input  logic              reset,
	input  alu_pkg::exe_t     exe,
	input  logic              exe_valid,
	output alu_pkg::alu_res_t res,
	output logic              out_valid
);

	import alu_pkg::*;

	flags_t flags;

	// zero test width follows the class
	always_comb
	begin
		if (exe.hold)
		begin
			// nothing changes, flags go back out as they came
			flags = exe.flags_in;
		end
		else
		begin
			flags.c = exe.c;
			if (exe.op_class == class_byte)
				flags.z = (exe.result[byte_w-1:0] == '0);
			else
				flags.z = (exe.result == '0);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= exe_valid;
	end

	always_ff @(posedge clk)
	begin
		if (exe_valid)
		begin
			res.result <= exe.result;
			res.flags <= flags;
		end
	end

endmodule

//--- src/alu_pipeline.sv
// three-stage ALU; result comes out exactly three cycles after in_valid, no back-pressure
module alu_pipeline
(
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  alu_pkg::alu_req_t req,
	output logic              out_valid,
	output alu_pkg::alu_res_t res
);

	import alu_pkg::*;

	dec_t dec;
	logic dec_valid;
	exe_t exe;
	logic exe_valid;

	// decode and classify
	alu_decode u_decode
	(
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.req       (req),
		.dec       (dec),
		.dec_valid (dec_valid)
	);

	// compute
	alu_execute u_execute
	(
		.clk       (clk),
		.reset     (reset),
		.dec       (dec),
		.dec_valid (dec_valid),
		.exe       (exe),
		.exe_valid (exe_valid)
	);

	// zero flag and output register
	alu_flags u_flags
	(
		.clk       (clk),
		.reset     (reset),
		.exe       (exe),
		.exe_valid (exe_valid),
		.res       (res),
		.out_valid (out_valid)
	);

endmodule

//--- test/alu_ref.svh
// included inside the testbench module body; relies on its error counters and on alu_pkg types
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

	// expected result straight from the instruction rules
	function automatic alu_res_t ref_result(input alu_req_t r);
		alu_res_t    o;
		byte_t       al;
		byte_t       bl;
		byte_t       bx;
		pair_t       px;
		pair_t       v;
		logic [8:0]  s9;
		logic [16:0] s17;
		logic        cx;
		logic        sgn;
		logic        pair_op;
		logic        keep;
		int          msb;
		int          n;
		al = r.a[7:0];
		bl = r.b[7:0];
		n = int'(bl);
		o.result = r.a;
		o.flags = r.flags;
		pair_op = 1'b0;
		keep = 1'b0;
		case (r.op)
			op_add, op_adc, op_sub, op_sbc:
			begin
				// subtract is add of the inverse, carry means no borrow
				bx = (r.op == op_sub || r.op == op_sbc) ? ~bl : bl;
				cx = (r.op == op_add) ? 1'b0 : (r.op == op_sub) ? 1'b1 : r.flags.c;
				s9 = {1'b0, al} + {1'b0, bx} + {8'h00, cx};
				o.result = {8'h00, s9[7:0]};
				o.flags.c = s9[8];
			end
			op_addpb, op_addp, op_addpsnx, op_subpb, op_subp:
			begin
				case (r.op)
					op_addpb:   px = {8'h00, bl};
					op_addp:    px = r.b;
					op_addpsnx: px = {{8{bl[7]}}, bl};
					op_subpb:   px = ~{8'h00, bl};
					default:    px = ~r.b;
				endcase
				cx = (r.op == op_subpb || r.op == op_subp);
				s17 = {1'b0, r.a} + {1'b0, px} + {16'h0000, cx};
				o.result = s17[15:0];
				o.flags.c = s17[16];
				pair_op = 1'b1;
			end
			// carry untouched from here down to the shifts
			op_and: o.result = {8'h00, al & bl};
			op_orr: o.result = {8'h00, al | bl};
			op_xor: o.result = {8'h00, al ^ bl};
			op_inv: o.result = {8'h00, ~al};
			op_neg: o.result = {8'h00, 8'h00 - al};
			op_invp:
			begin
				o.result = ~r.a;
				pair_op = 1'b1;
			end
			op_negp:
			begin
				o.result = 16'h0000 - r.a;
				pair_op = 1'b1;
			end
			op_lsl, op_lsr, op_asr, op_lslp, op_lsrp, op_asrp:
			begin
				pair_op = r.op inside {op_lslp, op_lsrp, op_asrp};
				msb = pair_op ? 15 : 7;
				v = pair_op ? r.a : {8'h00, al};
				keep = (n == 0);
				// one bit per step, c follows the bit that falls off
				for (int i = 0; i < n; i++)
				begin
					sgn = v[msb];
					if (r.op == op_lsl || r.op == op_lslp)
					begin
						o.flags.c = v[msb];
						v = v << 1;
					end
					else
					begin
						o.flags.c = v[0];
						v = v >> 1;
						if (r.op == op_asr || r.op == op_asrp)
							v[msb] = sgn;
					end
				end
				o.result = pair_op ? v : {8'h00, v[7:0]};
			end
			default: keep = 1'b1;
		endcase
		if (keep)
		begin
			o.result = r.a;
			o.flags = r.flags;
		end
		else
			o.flags.z = pair_op ? (o.result == 16'h0000) : (o.result[7:0] == 8'h00);
		return o;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			value_errors++;
			$display("Fail at %0t %s got %0h expected %0h", $time, name, got, expected);
		end
	endtask

`endif

//--- test/tb_alu_pipeline.sv
// random requests from a fixed seed; expected results are due exactly three negedges after issue
module tb_alu_pipeline;

	import alu_pkg::*;

	localparam int n_addsub = 2000;
	localparam int n_logic = 210;
	localparam int n_shift = 504;
	localparam int n_undef = 40;
	localparam int n_mixed = 300;
	localparam int total_ops = n_addsub + n_logic + n_shift + n_undef + n_mixed;
	localparam int max_cycles = 2 * total_ops + 50;

	logic     clk;
	logic     reset;
	logic     in_valid;
	alu_req_t req;
	logic     out_valid;
	alu_res_t res;

	logic [31:0] rng_state;
	int          cycle = 0;
	bit          checking = 1'b0;
	int          checks = 0;
	int          value_errors = 0;
	int          order_errors = 0;
	alu_res_t    exp_q[$];
	int          due_q[$];
	alu_res_t    exp_res;
	int          exp_due;

	alu_op_t addsub_ops[9] = '{op_add, op_adc, op_addpb, op_addp, op_addpsnx,
		op_sub, op_sbc, op_subpb, op_subp};
	alu_op_t logic_ops[7] = '{op_and, op_orr, op_xor, op_inv, op_invp, op_neg, op_negp};
	alu_op_t shift_ops[6] = '{op_lsl, op_lsr, op_asr, op_lslp, op_lsrp, op_asrp};

	`include "alu_ref.svh"

	alu_pipeline DUT
	(
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.res       (res)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// rising edge count doubles as the run limit
	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (cycle > max_cycles)
		begin
			$display("timeout after %0d cycles with %0d results outstanding", cycle, due_q.size());
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// outputs sampled mid cycle
	always @(negedge clk)
	begin
		if (checking)
		begin
			if (out_valid === 1'b1)
			begin
				if (exp_q.size() == 0)
				begin
					order_errors++;
					$display("result at %0t arrived with no request outstanding", $time);
				end
				else
				begin
					exp_res = exp_q.pop_front();
					exp_due = due_q.pop_front();
					check_value("out_valid cycle", cycle, exp_due);
					check_value("res.result", res.result, exp_res.result);
					check_value("res.flags.c", res.flags.c, exp_res.flags.c);
					check_value("res.flags.z", res.flags.z, exp_res.flags.z);
				end
			end
			else if (out_valid !== 1'b0)
			begin
				order_errors++;
				$display("out_valid is unknown at %0t", $time);
			end
			else if (due_q.size() != 0 && due_q[0] <= cycle)
			begin
				order_errors++;
				$display("result due in cycle %0d never came out", due_q[0]);
				exp_res = exp_q.pop_front();
				exp_due = due_q.pop_front();
			end
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// edge values show up often enough to hit carry and zero corners
	function automatic pair_t rand_pair();
		logic [31:0] t;
		t = next_rand();
		case (t[31:28])
			4'd0: return 16'h0000;
			4'd1: return 16'hffff;
			4'd2: return {t[15:8], 8'h00};
			4'd3: return {t[15:8], 8'hff};
			4'd4: return {t[15:8], 8'h80};
			default: return t[15:0];
		endcase
	endfunction

	function automatic flags_t rand_flags();
		logic [31:0] t;
		t = next_rand();
		return t[1:0];
	endfunction

	task automatic send_req(input alu_op_t op, input pair_t a, input pair_t b, input flags_t f);
		alu_req_t r;
		r.op = op;
		r.a = a;
		r.b = b;
		r.flags = f;
		@(negedge clk);
		in_valid = 1'b1;
		req = r;
		// three register stages, so it shows three negedges after this one
		exp_q.push_back(ref_result(r));
		due_q.push_back(cycle + 3);
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	initial
	begin
		logic [31:0] t;
		int          code;
		reset = 1'b1;
		in_valid = 1'b0;
		req = '0;
		rng_state = 32'hcfb6383a;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		checking = 1'b1;
		// quiet output before any request
		repeat (4)
		begin
			@(negedge clk);
			check_value("out_valid", out_valid, 1'b0);
		end
		for (int i = 0; i < n_addsub; i++)
		begin
			t = next_rand();
			send_req(addsub_ops[t % 9], rand_pair(), rand_pair(), rand_flags());
		end
		for (int i = 0; i < n_logic; i++)
			send_req(logic_ops[i % 7], rand_pair(), rand_pair(), rand_flags());
		// amounts 0 to 20 with four data values each
		for (int s = 0; s < 6; s++)
			for (int amt = 0; amt <= 20; amt++)
				for (int k = 0; k < 4; k++)
				begin
					t = next_rand();
					send_req(shift_ops[s], rand_pair(), {t[15:8], byte_t'(amt)}, rand_flags());
				end
		for (int op = 22; op < 32; op++)
			for (int k = 0; k < 4; k++)
				send_req(alu_op_t'(op[4:0]), rand_pair(), rand_pair(), rand_flags());
		// any opcode including undefined 22 and 23 with idle gaps
		for (int i = 0; i < n_mixed; i++)
		begin
			t = next_rand();
			if (t[8])
				idle_cycle();
			code = int'(t[7:0]) % 24;
			send_req(alu_op_t'(code[4:0]), rand_pair(), rand_pair(), rand_flags());
		end
		idle_cycle();
		while (due_q.size() != 0)
			@(negedge clk);
		// catch stray extra results
		repeat (5) @(negedge clk);
		$display("checks %0d, value errors %0d, order errors %0d",
			checks, value_errors, order_errors);
		if (value_errors == 0 && order_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+test
src/alu_pkg.sv
src/alu_decode.sv
src/addsub_unit.sv
src/shift_logic_unit.sv
src/alu_execute.sv
src/alu_flags.sv
src/alu_pipeline.sv
test/tb_alu_pipeline.sv

//--- Makefile
# Verilator build and run of the ALU pipeline testbench
VERILATOR ?= verilator
TOP       ?= tb_alu_pipeline
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
